// File: hdl/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    typedef logic [7:0] i2c_byte_t;

    // bit position inside a frame, 23 down to 0
    typedef logic [4:0] i2c_bit_idx_t;

    // sent msb first, so dev_addr goes out first
    typedef struct packed {
        i2c_byte_t dev_addr;
        i2c_byte_t reg_addr;
        i2c_byte_t data;
    } i2c_frame_t;

    typedef struct packed {
        logic scl;
        logic sda_out;
        logic sda_oe;      // low only in ack slots
    } i2c_bus_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START,
        ENG_DATA,
        ENG_ACK,
        ENG_STOP
    } eng_state_t;

endpackage

`default_nettype wire

// File: hdl/codec_cfg_pkg.sv
`default_nettype none

package codec_cfg_pkg;

    localparam int CFG_LEN = 10;    // entries in the table below

    typedef i2c_bus_pkg::i2c_frame_t cfg_word_t;
    typedef logic [3:0] cfg_idx_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_WAIT,
        SEQ_COOLDOWN
    } seq_state_t;

    localparam logic [7:0] CODEC_DEV_ADDR = 8'h34;

    // power-up register writes, register k at entry k
    localparam cfg_word_t CFG_TABLE [CFG_LEN] = '{
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h00, data: 8'h97},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h01, data: 8'h97},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h02, data: 8'h79},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h03, data: 8'h79},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h04, data: 8'h15},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h05, data: 8'h00},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h06, data: 8'h00},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h07, data: 8'h42},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h08, data: 8'h19},
        '{dev_addr: CODEC_DEV_ADDR, reg_addr: 8'h09, data: 8'h01}
    };

endpackage

`default_nettype wire

// File: hdl/codec_reg_rom.sv
`timescale 1ns/1ps
`default_nettype none

module codec_reg_rom #(
    parameter int NUM_REGS = 10
) (
    input  wire codec_cfg_pkg::cfg_idx_t  i_idx,
    output codec_cfg_pkg::cfg_word_t      o_word
);

    import codec_cfg_pkg::*;

    logic in_range;

    // beyond the active entries or the table itself, hand out zero
    assign in_range = (int'(i_idx) < NUM_REGS) && (int'(i_idx) < CFG_LEN);

    always_comb begin
        if (in_range) begin
            o_word = CFG_TABLE[i_idx];
        end else begin
            o_word = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_write_engine (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_go,
    input  wire i2c_bus_pkg::i2c_frame_t i_frame,
    input  wire logic                    i_sda_in,
    output i2c_bus_pkg::i2c_bus_t        o_bus,
    output logic                         o_done,
    output logic                         o_nack
);

    import i2c_bus_pkg::*;

    eng_state_t   state_q;
    i2c_bit_idx_t bit_q;     // bit currently on the line
    logic [23:0]  data_q;    // latched frame, msb first
    logic         nack_q;

    assign o_nack = nack_q;  // valid alongside o_done

    always_ff @(posedge i_clk) begin
        if (i_go && state_q == ENG_IDLE) begin
            data_q <= i_frame;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ENG_IDLE;
            bit_q   <= '0;
            nack_q  <= 1'b0;
            o_done  <= 1'b0;
            o_bus   <= '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b1};
        end else begin
            o_done <= 1'b0;
            case (state_q)
                ENG_IDLE: begin
                    if (i_go) begin
                        state_q <= ENG_START;
                        bit_q   <= 5'd23;
                        nack_q  <= 1'b0;
                    end
                end
                ENG_START: begin
                    if (o_bus.sda_out) begin
                        o_bus.sda_out <= 1'b0;       // sda falls, scl still high
                    end else begin
                        o_bus.scl     <= 1'b0;
                        o_bus.sda_out <= data_q[bit_q];
                        state_q       <= ENG_DATA;
                    end
                end
                ENG_DATA: begin
                    o_bus.scl <= ~o_bus.scl;
                    if (o_bus.scl) begin             // end of high half
                        if (bit_q[2:0] == 3'd0) begin
                            // byte done, release the line for the target
                            o_bus.sda_oe  <= 1'b0;
                            o_bus.sda_out <= 1'b0;
                            state_q       <= ENG_ACK;
                        end else begin
                            bit_q         <= bit_q - 5'd1;
                            o_bus.sda_out <= data_q[bit_q - 5'd1];
                        end
                    end
                end
                ENG_ACK: begin
                    o_bus.scl <= ~o_bus.scl;
                    if (o_bus.scl) begin
                        nack_q       <= nack_q | i_sda_in;  // high means no ack
                        o_bus.sda_oe <= 1'b1;
                        if (bit_q == 5'd0) begin
                            o_bus.sda_out <= 1'b0;      // held low for STOP
                            state_q       <= ENG_STOP;
                        end else begin
                            bit_q         <= bit_q - 5'd1;
                            o_bus.sda_out <= data_q[bit_q - 5'd1];
                            state_q       <= ENG_DATA;
                        end
                    end
                end
                ENG_STOP: begin
                    if (!o_bus.scl) begin
                        o_bus.scl <= 1'b1;
                    end else if (!o_bus.sda_out) begin
                        o_bus.sda_out <= 1'b1;          // sda rises with scl high
                    end else begin
                        o_done  <= 1'b1;
                        state_q <= ENG_IDLE;
                    end
                end
                default: begin
                    state_q <= ENG_IDLE;
                end
            endcase
        end
    end

    // data may only move with scl low, START and STOP edges excepted
    a_sda_with_scl_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($changed(o_bus.sda_out) && !($past(state_q) inside {ENG_START, ENG_STOP}))
            |-> !o_bus.scl);

    // sequencer must wait for done before the next frame
    a_go_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_go |-> state_q == ENG_IDLE);

endmodule

`default_nettype wire

// File: hdl/codec_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_seq #(
    parameter int NUM_REGS        = 10,
    parameter int COOLDOWN_CYCLES = 24
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_start,
    input  wire logic              i_frame_done,
    input  wire logic              i_frame_nack,
    output codec_cfg_pkg::cfg_idx_t o_idx,
    output logic                   o_frame_go,
    output logic                   o_finished,
    output logic                   o_busy,
    output logic                   o_nack_err
);

    import codec_cfg_pkg::*;

    localparam int CW = $clog2(COOLDOWN_CYCLES + 1);

    seq_state_t    state_q;
    logic [CW-1:0] cool_q;   // cycles left before a start is taken again

    assign o_frame_go = (state_q == SEQ_SEND);
    assign o_busy     = (state_q == SEQ_SEND) || (state_q == SEQ_WAIT);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= SEQ_IDLE;
            o_idx      <= '0;
            cool_q     <= '0;
            o_finished <= 1'b0;
            o_nack_err <= 1'b0;
        end else begin
            o_finished <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (i_start) begin
                        o_idx      <= '0;
                        o_nack_err <= 1'b0;   // new run, fresh error flag
                        state_q    <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    state_q <= SEQ_WAIT;      // go is one cycle wide
                end
                SEQ_WAIT: begin
                    if (i_frame_done) begin
                        if (i_frame_nack) begin
                            o_nack_err <= 1'b1;
                        end
                        if (o_idx == cfg_idx_t'(NUM_REGS - 1)) begin
                            o_finished <= 1'b1;
                            cool_q     <= CW'(COOLDOWN_CYCLES - 1);
                            state_q    <= SEQ_COOLDOWN;
                        end else begin
                            o_idx   <= o_idx + 4'd1;
                            state_q <= SEQ_SEND;
                        end
                    end
                end
                SEQ_COOLDOWN: begin
                    if (cool_q == '0) begin
                        state_q <= SEQ_IDLE;
                    end else begin
                        cool_q <= cool_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    a_finished_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_finished |=> !o_finished);

endmodule

`default_nettype wire

// File: hdl/codec_init_top.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_top #(
    parameter int NUM_REGS        = 10,
    parameter int COOLDOWN_CYCLES = 24
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start,
    input  wire logic i_sda_in,   // resolved line
    output logic      o_scl,
    output logic      o_sda,
    output logic      o_sda_oe,
    output logic      o_finished,
    output logic      o_busy,
    output logic      o_nack_err
);

    import i2c_bus_pkg::*;
    import codec_cfg_pkg::*;

    cfg_idx_t  idx;
    cfg_word_t word;
    logic      frame_go;
    logic      frame_done;
    logic      frame_nack;
    i2c_bus_t  bus;

    codec_reg_rom #(
        .NUM_REGS (NUM_REGS)
    ) u_rom (
        .i_idx  (idx),
        .o_word (word)
    );

    codec_init_seq #(
        .NUM_REGS        (NUM_REGS),
        .COOLDOWN_CYCLES (COOLDOWN_CYCLES)
    ) u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_frame_done (frame_done),
        .i_frame_nack (frame_nack),
        .o_idx        (idx),
        .o_frame_go   (frame_go),
        .o_finished   (o_finished),
        .o_busy       (o_busy),
        .o_nack_err   (o_nack_err)
    );

    i2c_write_engine u_eng (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_go     (frame_go),
        .i_frame  (word),
        .i_sda_in (i_sda_in),
        .o_bus    (bus),
        .o_done   (frame_done),
        .o_nack   (frame_nack)
    );

    assign o_scl    = bus.scl;
    assign o_sda    = bus.sda_oe ? bus.sda_out : 1'b1;  // released reads as high
    assign o_sda_oe = bus.sda_oe;

endmodule

`default_nettype wire

// File: verif/i2c_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model (
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_scl,
    input  wire logic   i_sda_dut,    // high when the DUT releases
    input  wire logic   i_withhold,   // leave ack slots undriven
    output logic        o_sda,        // resolved line
    output logic        o_frame_stb,
    output logic [23:0] o_frame,
    output logic [4:0]  o_frame_bits
);

    logic        ack_drive;
    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic [4:0]  bit_cnt;    // scl rises so far, ack slots included
    logic [23:0] shift;

    assign o_sda = i_sda_dut & ~ack_drive;  // wired-AND

    function automatic logic is_ack_slot(input logic [4:0] n);
        return (n == 5'd8) || (n == 5'd17) || (n == 5'd26);
    endfunction

    // lines looked at mid-cycle, away from the DUT clock edge
    always @(negedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            in_frame     <= 1'b0;
            bit_cnt      <= '0;
            shift        <= '0;
            ack_drive    <= 1'b0;
            o_frame_stb  <= 1'b0;
            o_frame      <= '0;
            o_frame_bits <= '0;
        end else begin
            scl_q       <= i_scl;
            sda_q       <= o_sda;
            o_frame_stb <= 1'b0;
            if (scl_q && i_scl && sda_q && !o_sda) begin
                in_frame <= 1'b1;                      // START
                bit_cnt  <= '0;
                shift    <= '0;
            end else if (scl_q && i_scl && !sda_q && o_sda) begin
                if (in_frame) begin                    // STOP closes the frame
                    o_frame_stb  <= 1'b1;
                    o_frame      <= shift;
                    o_frame_bits <= bit_cnt;
                end
                in_frame <= 1'b0;
            end else if (in_frame && !scl_q && i_scl && bit_cnt < 5'd27) begin
                // the rise ahead of STOP carries no bit
                if (!is_ack_slot(bit_cnt)) begin
                    shift <= {shift[22:0], o_sda};
                end
                bit_cnt <= bit_cnt + 5'd1;
            end else if (in_frame && scl_q && !i_scl) begin
                ack_drive <= is_ack_slot(bit_cnt) && !i_withhold;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_codec_init.sv
`timescale 1ns/1ps
`default_nettype none

module tb_codec_init;

    localparam int NUM_REGS        = 10;
    localparam int COOLDOWN_CYCLES = 24;
    localparam int FRAME_CYCLES    = 56;
    localparam int MAX_FRAMES      = 512;

    logic clk = 1'b0;
    logic rst_n;
    logic start;
    logic sda_line;
    logic scl;
    logic sda_dut;
    logic sda_oe;
    logic finished;
    logic busy;
    logic nack_err;
    logic withhold;
    logic frame_stb;
    logic [23:0] frame;
    logic [4:0]  frame_bits;

    logic [23:0] mem [0:63];
    logic [23:0] exp_words [0:NUM_REGS-1];
    logic [23:0] cap_frames [0:MAX_FRAMES-1];
    logic [4:0]  cap_bits [0:MAX_FRAMES-1];
    int     cap_cnt = 0;
    int     run_base = 0;
    int     nack_sel = -1;     // frame of the current run without ack
    int     num_cases = 0;
    int     checks = 0;
    int     errors = 0;
    integer seed = 32'hc153;
    bit     loaded = 1'b0;

    always #4 clk = ~clk;

    assign withhold = (nack_sel == cap_cnt - run_base);

    codec_init_top #(
        .NUM_REGS        (NUM_REGS),
        .COOLDOWN_CYCLES (COOLDOWN_CYCLES)
    ) u_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_sda_in   (sda_line),
        .o_scl      (scl),
        .o_sda      (sda_dut),
        .o_sda_oe   (sda_oe),
        .o_finished (finished),
        .o_busy     (busy),
        .o_nack_err (nack_err)
    );

    i2c_target_model u_target (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_scl        (scl),
        .i_sda_dut    (sda_dut),
        .i_withhold   (withhold),
        .o_sda        (sda_line),
        .o_frame_stb  (frame_stb),
        .o_frame      (frame),
        .o_frame_bits (frame_bits)
    );

    // strobe moves on the falling edge, so pick it up on the rising one
    always @(posedge clk) begin
        if (frame_stb && cap_cnt < MAX_FRAMES) begin
            cap_frames[cap_cnt] = frame;
            cap_bits[cap_cnt]   = frame_bits;
            cap_cnt++;
        end
    end

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @ %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic run_case(input int num, input int nack_idx, input int exp_err);
        int  delay;
        int  fins;
        int  err_before;
        bit  extra_sent;
        delay      = ($random(seed) & 7) + 1;
        fins       = 0;
        extra_sent = 1'b0;
        err_before = errors;
        repeat (delay) @(negedge clk);
        nack_sel = nack_idx;
        run_base = cap_cnt;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("busy after start", busy, 1);
        check_value("error flag after start", nack_err, 0);
        while (!finished) begin
            @(negedge clk);
            start = 1'b0;
            if (!finished) begin
                check_value("busy during run", busy, 1);
            end
            if (!extra_sent && cap_cnt - run_base == 1) begin
                start      = 1'b1;              // while busy, must be ignored
                extra_sent = 1'b1;
            end
        end
        fins = 1;
        check_value("busy at finish", busy, 0);
        check_value("frames at finish", cap_cnt - run_base, NUM_REGS);
        check_value("error flag at finish", nack_err, exp_err);
        for (int i = 0; i < COOLDOWN_CYCLES + 6; i++) begin
            @(negedge clk);
            start = (i == 1);                   // lands inside cooldown
            if (finished) begin
                fins++;
            end
            check_value("busy in cooldown", busy, 0);
        end
        check_value("finished pulses", fins, 1);
        check_value("frames after cooldown", cap_cnt - run_base, NUM_REGS);
        check_value("sticky error flag", nack_err, exp_err);
        for (int k = 0; k < NUM_REGS && run_base + k < MAX_FRAMES; k++) begin
            check_value($sformatf("bits in frame %0d", k), cap_bits[run_base + k], 27);
            check_value($sformatf("frame %0d", k), cap_frames[run_base + k], exp_words[k]);
        end
        nack_sel = -1;
        $display("case %0d: nack frame %0d, error flag %0d: %s", num, nack_idx, exp_err,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int nack_idx;
        start = 1'b0;
        rst_n = 1'b0;
        $readmemh("verif/init_cases.txt", mem);
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_words[i] = mem[i];
        end
        num_cases = int'(mem[NUM_REGS]);
        loaded    = 1'b1;
        repeat (4) @(posedge clk);
        check_value("scl in reset", scl, 1);
        check_value("sda in reset", sda_dut, 1);
        check_value("sda_oe in reset", sda_oe, 1);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (20) @(negedge clk);
        check_value("scl idle", scl, 1);
        check_value("sda idle", sda_dut, 1);
        check_value("flags idle", {finished, busy, nack_err}, 0);
        check_value("frames without start", cap_cnt, 0);
        $display("reset: idle lines and flags %s", (errors == 0) ? "ok" : "mismatch");
        for (int c = 0; c < num_cases; c++) begin
            nack_idx = int'(mem[NUM_REGS + 1 + 2 * c]);
            if (nack_idx == 'hff) begin
                nack_idx = -1;                  // all acks given
            end
            run_case(c, nack_idx, int'(mem[NUM_REGS + 2 + 2 * c]));
        end
        $display("cases %0d, checks %0d, errors %0d", num_cases, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // limit scales with the number of cases in the file
    initial begin
        wait (loaded);
        repeat (2000 * FRAME_CYCLES * num_cases) @(posedge clk);
        $display("timeout: the cases did not complete within %0d cycles",
                 2000 * FRAME_CYCLES * num_cases);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hdl/i2c_bus_pkg.sv
hdl/codec_cfg_pkg.sv
hdl/codec_reg_rom.sv
hdl/i2c_write_engine.sv
hdl/codec_init_seq.sv
hdl/codec_init_top.sv
verif/i2c_target_model.sv
verif/tb_codec_init.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_codec_init -f sim.f -o sim_codec_init

out=$(./obj_dir/sim_codec_init)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// File: verif/init_cases.txt
// ten expected table words, hex: device address, register, data
340097
340197
340279
340379
340415
340500
340600
340742
340819
340901
// case count, then per case: nack frame index (ff = none), expected error flag
5
ff 0
3  1
ff 0
9  1
0  1
